/* tb.f */
logic/i8080_pkg.sv
logic/apb_port.sv
logic/op_decoder.sv
logic/reg_bank.sv
logic/alu_datapath.sv
logic/exec_core.sv
sim/tb_exec_core.sv

/* Bender.yml */
package:
  name: i8080_exec

sources:
  # execution unit RTL, package first
  - files:
      - logic/i8080_pkg.sv
      - logic/apb_port.sv
      - logic/op_decoder.sv
      - logic/reg_bank.sv
      - logic/alu_datapath.sv
      - logic/exec_core.sv

  # testbench
  - target: simulation
    files:
      - sim/tb_exec_core.sv

/* sim/tb_exec_core.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_exec_core import i8080_pkg::*; ();

   localparam int CLK_PERIOD   = 8;
   localparam int RESET_CYCLES = 16;
   // about 620 accesses in all tests, each at most 5 cycles with its idle cycle
   localparam int MAX_ACCESSES      = 800;
   localparam int CYCLES_PER_ACCESS = 5;

   logic              clk;
   logic              reset;
   logic              psel;
   logic              penable;
   logic              pwrite;
   logic [ADDR_W-1:0] paddr;
   logic [DATA_W-1:0] pwdata;
   logic [DATA_W-1:0] prdata;
   logic              pready;
   logic              pslverr;

   // expected response of the access on the bus
   logic [DATA_W-1:0] exp_rdata;
   logic              exp_err;

   // model state, indexed by register code, 7 is A
   logic [DATA_W-1:0] m_reg [8];
   flags_t            m_flags;

   integer seed;
   int     errors;
   int     errors_at_start;
   int     tests_run;
   int     tests_failed;

   exec_core exec_core_inst (
      .clk     (clk),
      .reset   (reset),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial
   begin
      #(CLK_PERIOD * (RESET_CYCLES + MAX_ACCESSES * CYCLES_PER_ACCESS));
      $display("watchdog expired after %0d access slots, the DUT stopped responding",
               MAX_ACCESSES);
      $display("SOME TESTS FAILED");
      $finish;
   end

   a_read_data: assert property (@(posedge clk) disable iff (reset)
      (psel && penable && pready && !pwrite) |-> (prdata == exp_rdata))
   else
   begin
      errors++;
      $display("** Error at %0t ns: prdata expected 8'h%02h, actual 8'h%02h",
               $time, $sampled(exp_rdata), $sampled(prdata));
   end

   a_read_err: assert property (@(posedge clk) disable iff (reset)
      (psel && penable && pready && !pwrite) |-> (pslverr == exp_err))
   else
   begin
      errors++;
      $display("** Error at %0t ns: pslverr on read of 4'h%h expected %b, actual %b",
               $time, $sampled(paddr), $sampled(exp_err), $sampled(pslverr));
   end

   a_write_err: assert property (@(posedge clk) disable iff (reset)
      (psel && penable && pready && pwrite) |-> (pslverr == exp_err))
   else
   begin
      errors++;
      $display("** Error at %0t ns: pslverr on write of 4'h%h expected %b, actual %b",
               $time, $sampled(paddr), $sampled(exp_err), $sampled(pslverr));
   end

   // opcode writes take exactly three access cycles
   a_opcode_len: assert property (@(posedge clk) disable iff (reset)
      (psel && $rose(penable) && pwrite && paddr == ADDR_OPCODE)
         |-> (!pready ##1 !pready ##1 pready))
   else
   begin
      errors++;
      $display("opcode write ending at %0t ns did not take exactly 3 access cycles", $time);
   end

   a_reg_len: assert property (@(posedge clk) disable iff (reset)
      (psel && $rose(penable) && !(pwrite && paddr == ADDR_OPCODE)) |-> pready)
   else
   begin
      errors++;
      $display("register access at %0t ns did not finish in its first access cycle", $time);
   end

   function automatic logic [DATA_W-1:0] rand_byte();
      return DATA_W'($random(seed));
   endfunction

   // any code of B to L or A
   function automatic logic [2:0] rand_reg();
      int k;
      k = {$random(seed)} % 7;
      return (k == 6) ? 3'd7 : 3'(k);
   endfunction

   function automatic logic is_reg_addr(input logic [ADDR_W-1:0] addr);
      return (addr <= 4'd5) || (addr == 4'd7);
   endfunction

   function automatic logic [DATA_W-1:0] psw_byte();
      logic [DATA_W-1:0] b;
      b          = 8'h02;
      b[FLAG_S]  = m_flags.s;
      b[FLAG_Z]  = m_flags.z;
      b[FLAG_AC] = m_flags.ac;
      b[FLAG_P]  = m_flags.p;
      b[FLAG_C]  = m_flags.c;
      return b;
   endfunction

   // result is {carry out of bit 7, carry out of bit 3, sum}
   function automatic logic [9:0] add_carry(input logic [7:0] x, input logic [7:0] y,
                                            input logic cin);
      logic [8:0] full;
      logic [4:0] low;
      full = {1'b0, x} + {1'b0, y} + 9'(cin);
      low  = {1'b0, x[3:0]} + {1'b0, y[3:0]} + 5'(cin);
      return {full[8], low[4], full[7:0]};
   endfunction

   task automatic set_szp(input logic [7:0] v);
      m_flags.s = v[7];
      m_flags.z = (v == 8'h00);
      m_flags.p = ~^v;
   endtask

   task automatic model_exec(input logic [7:0] opc, output logic legal);
      logic [2:0] d;
      logic [2:0] s;
      logic [7:0] a;
      logic [7:0] v;
      logic [9:0] r;
      logic [8:0] t;
      logic [7:0] fix;
      logic       lo;
      logic       hi;
      d     = opc[5:3];
      s     = opc[2:0];
      a     = m_reg[7];
      legal = 1'b1;
      casez (opc)
         8'b00000000:
            legal = 1'b1;
         8'b01??????:
            if (d == 3'd6 || s == 3'd6)
               legal = 1'b0;
            else
               m_reg[d] = m_reg[s];
         8'b00???100, 8'b00???101:
            if (d == 3'd6)
               legal = 1'b0;
            else
            begin
               // dcr adds all ones, carry stays
               v = m_reg[d];
               r = opc[0] ? add_carry(v, 8'hFF, 1'b0) : add_carry(v, 8'h00, 1'b1);
               m_reg[d]   = r[7:0];
               m_flags.ac = r[8];
               set_szp(r[7:0]);
            end
         8'b10??????:
            if (s == 3'd6)
               legal = 1'b0;
            else
            begin
               v = m_reg[s];
               case (d)
                  3'd0:    r = add_carry(a, v, 1'b0);
                  3'd1:    r = add_carry(a, v, m_flags.c);
                  3'd3:    r = add_carry(a, ~v, ~m_flags.c);
                  3'd4:    r = {1'b0, a[3] | v[3], a & v};
                  3'd5:    r = {2'b00, a ^ v};
                  3'd6:    r = {2'b00, a | v};
                  default: r = add_carry(a, ~v, 1'b1);
               endcase
               // subtracts report the borrow
               m_flags.c  = (d == 3'd2 || d == 3'd3 || d == 3'd7) ? ~r[9] : r[9];
               m_flags.ac = r[8];
               set_szp(r[7:0]);
               if (d != 3'd7)
                  m_reg[7] = r[7:0];
            end
         8'b00???111:
            case (d)
               3'd0:
               begin
                  m_reg[7]  = {a[6:0], a[7]};
                  m_flags.c = a[7];
               end
               3'd1:
               begin
                  m_reg[7]  = {a[0], a[7:1]};
                  m_flags.c = a[0];
               end
               3'd2:
               begin
                  m_reg[7]  = {a[6:0], m_flags.c};
                  m_flags.c = a[7];
               end
               3'd3:
               begin
                  m_reg[7]  = {m_flags.c, a[7:1]};
                  m_flags.c = a[0];
               end
               3'd4:
               begin
                  lo  = (a[3:0] > 4'd9) || m_flags.ac;
                  t   = {1'b0, a} + (lo ? 9'd6 : 9'd0);
                  hi  = (t[8:4] > 5'd9) || m_flags.c;
                  fix = {hi ? 4'h6 : 4'h0, lo ? 4'h6 : 4'h0};
                  r   = add_carry(a, fix, 1'b0);
                  m_reg[7]   = r[7:0];
                  m_flags.ac = r[8];
                  m_flags.c  = hi;
                  set_szp(r[7:0]);
               end
               3'd5:
                  m_reg[7] = ~a;
               3'd6:
                  m_flags.c = 1'b1;
               default:
                  m_flags.c = ~m_flags.c;
            endcase
         default:
            legal = 1'b0;
      endcase
   endtask

   // setup, access until pready, then one idle cycle
   task automatic apb_access(input logic is_write, input logic [ADDR_W-1:0] addr,
                             input logic [7:0] data, input logic [7:0] rdata_exp,
                             input logic err_exp);
      @(posedge clk);
      #1;
      psel      = 1'b1;
      penable   = 1'b0;
      pwrite    = is_write;
      paddr     = addr;
      pwdata    = data;
      exp_rdata = rdata_exp;
      exp_err   = err_exp;
      @(posedge clk);
      #1;
      penable = 1'b1;
      @(negedge clk);
      while (!pready)
         @(negedge clk);
      @(posedge clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [7:0] data);
      logic ok;
      ok = is_reg_addr(addr) || (addr == ADDR_PSW);
      apb_access(1'b1, addr, data, 8'h00, !ok);
      if (is_reg_addr(addr))
         m_reg[addr[2:0]] = data;
      else if (addr == ADDR_PSW)
         m_flags = '{s: data[FLAG_S], z: data[FLAG_Z], ac: data[FLAG_AC],
                     p: data[FLAG_P], c: data[FLAG_C]};
   endtask

   task automatic apb_read(input logic [ADDR_W-1:0] addr);
      if (is_reg_addr(addr))
         apb_access(1'b0, addr, 8'h00, m_reg[addr[2:0]], 1'b0);
      else if (addr == ADDR_PSW)
         apb_access(1'b0, addr, 8'h00, psw_byte(), 1'b0);
      else
         apb_access(1'b0, addr, 8'h00, 8'h00, 1'b1);
   endtask

   task automatic run_opcode(input logic [7:0] opc);
      logic legal;
      model_exec(opc, legal);
      apb_access(1'b1, ADDR_OPCODE, opc, 8'h00, !legal);
   endtask

   task automatic read_all();
      for (int k = 0; k < 8; k++)
      begin
         if (k != 6)
            apb_read(4'(k));
      end
      apb_read(ADDR_PSW);
   endtask

   task automatic finish_test(input string name);
      int n;
      n = errors - errors_at_start;
      tests_run++;
      if (n != 0)
         tests_failed++;
      $display("test %0d %s: %s", tests_run, name,
               (n == 0) ? "ok" : $sformatf("%0d errors", n));
      errors_at_start = errors;
   endtask

   initial
   begin
      logic [7:0] a;
      logic [7:0] b;
      logic [2:0] d;
      logic [2:0] s;
      logic [7:0] edge_val [4];
      logic [7:0] bad_ops [12];
      seed            = 32'hfa46;
      errors          = 0;
      errors_at_start = 0;
      tests_run       = 0;
      tests_failed    = 0;
      reset           = 1'b1;
      psel            = 1'b0;
      penable         = 1'b0;
      pwrite          = 1'b0;
      paddr           = '0;
      pwdata          = '0;
      exp_rdata       = '0;
      exp_err         = 1'b0;
      m_flags         = '0;
      for (int k = 0; k < 8; k++)
         m_reg[k] = 8'h00;
      edge_val = '{8'hFF, 8'h00, 8'h0F, 8'h10};
      bad_ops  = '{8'h46, 8'h70, 8'h76, 8'h34, 8'h35, 8'h86,
                   8'h3E, 8'hC6, 8'hC3, 8'hCD, 8'h01, 8'h08};
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      reset = 1'b0;

      read_all();
      apb_read(4'h6);
      apb_read(4'h9);
      apb_read(ADDR_OPCODE);
      for (int k = 0; k < 8; k++)
      begin
         if (k != 6)
            apb_write(4'(k), rand_byte());
      end
      apb_write(ADDR_PSW, rand_byte());
      apb_write(4'h9, rand_byte());
      read_all();
      finish_test("reset and readback");

      for (int op = 0; op < 8; op++)
      begin
         for (int k = 0; k < 7; k++)
         begin
            s = (k == 6) ? 3'd7 : 3'(k);
            apb_write(4'(s), rand_byte());
            if (s != 3'd7)
               apb_write(4'd7, rand_byte());
            apb_write(ADDR_PSW, rand_byte());
            run_opcode(8'h80 + 8'(op * 8 + s));
            apb_read(4'd7);
            apb_read(ADDR_PSW);
         end
      end
      finish_test("arithmetic group");

      for (int i = 0; i < 12; i++)
      begin
         d = rand_reg();
         s = rand_reg();
         apb_write(4'(s), rand_byte());
         run_opcode({2'b01, d, s});
         apb_read(4'(d));
      end
      // inr then dcr on nibble and byte boundaries
      for (int op = 0; op < 2; op++)
      begin
         for (int i = 0; i < 4; i++)
         begin
            d = rand_reg();
            apb_write(4'(d), edge_val[i]);
            apb_write(ADDR_PSW, {7'b0, 1'(i) ^ 1'(op)});
            run_opcode({2'b00, d, 2'b10, 1'(op)});
            apb_read(4'(d));
            apb_read(ADDR_PSW);
         end
      end
      finish_test("mov, inr and dcr");

      for (int k = 0; k < 8; k++)
      begin
         if (k != 4)
         begin
            for (int c = 0; c < 2; c++)
            begin
               apb_write(4'd7, rand_byte());
               apb_write(ADDR_PSW, {7'b0, 1'(c)});
               run_opcode({2'b00, 3'(k), 3'b111});
               apb_read(4'd7);
               apb_read(ADDR_PSW);
            end
         end
      end
      // daa after bcd addition
      for (int i = 0; i < 8; i++)
      begin
         a = {4'({$random(seed)} % 10), 4'({$random(seed)} % 10)};
         b = {4'({$random(seed)} % 10), 4'({$random(seed)} % 10)};
         apb_write(4'd7, a);
         apb_write(4'd0, b);
         run_opcode(8'h80);
         run_opcode(8'h27);
         apb_read(4'd7);
         apb_read(ADDR_PSW);
      end
      finish_test("accumulator group");

      for (int i = 0; i < 12; i++)
         run_opcode(bad_ops[i]);
      read_all();
      finish_test("illegal opcodes");

      // opcode writes mixed with register traffic
      for (int i = 0; i < 10; i++)
      begin
         d = rand_reg();
         apb_write(4'(d), rand_byte());
         run_opcode(8'h80 + 8'(({$random(seed)} % 8) * 8 + rand_reg()));
         run_opcode(8'h00);
         apb_read(4'(d));
      end
      read_all();
      finish_test("opcode access timing");

      $display("tests run %0d, tests with errors %0d, check errors %0d",
               tests_run, tests_failed, errors);
      if (errors == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* logic/exec_core.sv */
`timescale 1ns/10ps
`default_nettype none

module exec_core import i8080_pkg::*;
(
   input  logic              clk,
   input  logic              reset,
   input  logic              psel,
   input  logic              penable,
   input  logic              pwrite,
   input  logic [ADDR_W-1:0] paddr,
   input  logic [DATA_W-1:0] pwdata,
   output logic [DATA_W-1:0] prdata,
   output logic              pready,
   output logic              pslverr
);

   host_wr_t          host_wr;
   exec_req_t         dec_req;
   exec_req_t         req_q;
   flags_t            flags;
   reg_code_e         wr_sel;
   logic [DATA_W-1:0] opcode;
   logic [DATA_W-1:0] rd_a;
   logic [DATA_W-1:0] rd_b;
   logic [DATA_W-1:0] acc;
   logic [DATA_W-1:0] wr_data;
   logic              start;
   logic              go;
   logic              done;
   logic              wr_en;

   apb_port u_apb (
      .clk      (clk),
      .reset    (reset),
      .psel     (psel),
      .penable  (penable),
      .pwrite   (pwrite),
      .paddr    (paddr),
      .pwdata   (pwdata),
      .prdata   (prdata),
      .pready   (pready),
      .pslverr  (pslverr),
      .host_wr  (host_wr),
      .opcode   (opcode),
      .start    (start),
      .done     (done),
      .legal    (req_q.legal),
      .rd_reg   (rd_b),
      .rd_acc   (acc),
      .rd_flags (flags)
   );

   op_decoder u_dec (
      .opcode (opcode),
      .req    (dec_req)
   );

   // decode to execute stage
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         go <= 1'b0;
      else
         go <= start;
   end

   always_ff @(posedge clk)
   begin
      req_q <= dec_req;
   end

   // port b follows the apb address for readback
   reg_bank u_regs (
      .clk      (clk),
      .reset    (reset),
      .host_wr  (host_wr),
      .rd_sel_a (req_q.src),
      .rd_sel_b (reg_code_e'(paddr[2:0])),
      .rd_a     (rd_a),
      .rd_b     (rd_b),
      .wr_en    (wr_en),
      .wr_sel   (wr_sel),
      .wr_data  (wr_data)
   );

   alu_datapath u_alu (
      .clk     (clk),
      .reset   (reset),
      .req     (req_q),
      .go      (go),
      .host_wr (host_wr),
      .operand (rd_a),
      .acc     (acc),
      .flags   (flags),
      .wr_en   (wr_en),
      .wr_sel  (wr_sel),
      .wr_data (wr_data),
      .done    (done)
   );

endmodule

`default_nettype wire

/* logic/alu_datapath.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_datapath import i8080_pkg::*;
(
   input  logic              clk,
   input  logic              reset,
   input  exec_req_t         req,
   input  logic              go,
   input  host_wr_t          host_wr,
   input  logic [DATA_W-1:0] operand,
   output logic [DATA_W-1:0] acc,
   output flags_t            flags,
   output logic              wr_en,
   output reg_code_e         wr_sel,
   output logic [DATA_W-1:0] wr_data,
   output logic              done
);

   logic [DATA_W-1:0] src_val;
   logic [DATA_W-1:0] x;
   logic [DATA_W-1:0] r;
   logic [DATA_W-1:0] sum;
   logic [DATA_W-1:0] cy;
   logic [DATA_W-1:0] res;
   logic [DATA_W-1:0] daa_fix;
   logic [DATA_W:0]   daa_lo_sum;
   logic              cin;
   logic              carry;
   logic              tmp_c;
   logic              daa_lo;
   logic              daa_hi;
   logic              szp_upd;
   logic              exec;
   logic              reg_op;
   logic              acc_we;
   flags_t            flags_nxt;

   assign src_val = (req.src == reg_a) ? acc : operand;

   // decimal adjust, high check on the low-adjusted value
   assign daa_lo     = (acc[3:0] > 4'd9) | flags.ac;
   assign daa_lo_sum = {1'b0, acc} + (daa_lo ? 9'd6 : 9'd0);
   assign daa_hi     = daa_lo_sum[DATA_W] | (daa_lo_sum[7:4] > 4'd9) | flags.c;
   assign daa_fix    = {daa_hi ? 4'h6 : 4'h0, daa_lo ? 4'h6 : 4'h0};

   // adder inputs, subtract adds the inverted operand
   always_comb
   begin
      r   = acc;
      x   = src_val;
      cin = 1'b0;
      case (req.op)
         op_inr:
         begin
            r   = src_val;
            x   = '0;
            cin = 1'b1;
         end
         op_dcr:
         begin
            r = src_val;
            x = '1;
         end
         op_adc:
            cin = tmp_c;
         op_sub, op_cmp:
         begin
            x   = ~src_val;
            cin = 1'b1;
         end
         op_sbb:
         begin
            x   = ~src_val;
            cin = ~tmp_c;
         end
         op_daa:
            x = daa_fix;
         default:
            cin = 1'b0;
      endcase
   end

   // ripple carry chain
   always_comb
   begin
      carry = cin;
      for (int i = 0; i < DATA_W; i++)
      begin
         sum[i] = x[i] ^ r[i] ^ carry;
         carry  = (x[i] & r[i]) | (carry & (x[i] | r[i]));
         cy[i]  = carry;
      end
   end

   always_comb
   begin
      res       = acc;
      flags_nxt = flags;
      szp_upd   = 1'b0;
      case (req.op)
         op_mov:
            res = src_val;
         // c is kept
         op_inr, op_dcr:
         begin
            res          = sum;
            flags_nxt.ac = cy[3];
            szp_upd      = 1'b1;
         end
         op_add, op_adc:
         begin
            res          = sum;
            flags_nxt.ac = cy[3];
            flags_nxt.c  = cy[7];
            szp_upd      = 1'b1;
         end
         // carry out inverted gives the borrow
         op_sub, op_sbb, op_cmp:
         begin
            res          = sum;
            flags_nxt.ac = cy[3];
            flags_nxt.c  = ~cy[7];
            szp_upd      = 1'b1;
         end
         op_ana:
         begin
            res          = acc & src_val;
            flags_nxt.ac = acc[3] | src_val[3];
            flags_nxt.c  = 1'b0;
            szp_upd      = 1'b1;
         end
         op_xra, op_ora:
         begin
            res          = (req.op == op_xra) ? (acc ^ src_val) : (acc | src_val);
            flags_nxt.ac = 1'b0;
            flags_nxt.c  = 1'b0;
            szp_upd      = 1'b1;
         end
         op_rlc:
         begin
            res         = {acc[6:0], acc[7]};
            flags_nxt.c = acc[7];
         end
         op_rrc:
         begin
            res         = {acc[0], acc[7:1]};
            flags_nxt.c = acc[0];
         end
         op_ral:
         begin
            res         = {acc[6:0], tmp_c};
            flags_nxt.c = acc[7];
         end
         op_rar:
         begin
            res         = {tmp_c, acc[7:1]};
            flags_nxt.c = acc[0];
         end
         op_daa:
         begin
            res          = sum;
            flags_nxt.ac = cy[3];
            flags_nxt.c  = daa_hi;
            szp_upd      = 1'b1;
         end
         op_cma:
            res = ~acc;
         op_stc:
            flags_nxt.c = 1'b1;
         op_cmc:
            flags_nxt.c = ~flags.c;
         default:
            szp_upd = 1'b0;
      endcase
      if (szp_upd)
      begin
         flags_nxt.s = res[7];
         flags_nxt.z = (res == '0);
         flags_nxt.p = ~^res;
      end
   end

   assign exec   = go & req.legal;
   assign reg_op = (req.op == op_mov) | (req.op == op_inr) | (req.op == op_dcr);
   assign acc_we = exec & (req.dst == reg_a) & (req.op != op_cmp) & (req.op != op_nop);

   assign wr_en   = exec & reg_op & (req.dst != reg_a);
   assign wr_sel  = req.dst;
   assign wr_data = res;

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         acc   <= '0;
         flags <= '0;
         tmp_c <= 1'b0;
         done  <= 1'b0;
      end
      else
      begin
         done <= go;
         // carry copy taken ahead of the execute cycle
         if (!go)
            tmp_c <= flags.c;
         if (host_wr.valid && (host_wr.addr == ADDR_W'(reg_a)))
            acc <= host_wr.data;
         else if (acc_we)
            acc <= res;
         if (host_wr.valid && (host_wr.addr == ADDR_PSW))
            flags <= '{s:  host_wr.data[FLAG_S],
                       z:  host_wr.data[FLAG_Z],
                       ac: host_wr.data[FLAG_AC],
                       p:  host_wr.data[FLAG_P],
                       c:  host_wr.data[FLAG_C]};
         else if (exec)
            flags <= flags_nxt;
      end
   end

   // one go pulse per opcode, so done is a single cycle
   a_done_after_go: assert property (@(posedge clk) disable iff (reset)
      go |=> !go);

endmodule

`default_nettype wire

/* logic/reg_bank.sv */
`timescale 1ns/10ps
`default_nettype none

module reg_bank import i8080_pkg::*;
(
   input  logic              clk,
   input  logic              reset,
   input  host_wr_t          host_wr,
   input  reg_code_e         rd_sel_a,
   input  reg_code_e         rd_sel_b,
   output logic [DATA_W-1:0] rd_a,
   output logic [DATA_W-1:0] rd_b,
   input  logic              wr_en,
   input  reg_code_e         wr_sel,
   input  logic [DATA_W-1:0] wr_data
);

   // b, c, d, e, h, l
   logic [DATA_W-1:0] regs [6];
   logic              host_hit;

   assign host_hit = host_wr.valid && (host_wr.addr <= ADDR_W'(reg_l));

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         for (int i = 0; i < 6; i++)
            regs[i] <= '0;
      end
      else if (host_hit)
         regs[host_wr.addr[2:0]] <= host_wr.data;
      else if (wr_en && (wr_sel <= reg_l))
         regs[wr_sel] <= wr_data;
   end

   // codes m and a are not held here
   assign rd_a = (rd_sel_a <= reg_l) ? regs[rd_sel_a] : '0;
   assign rd_b = (rd_sel_b <= reg_l) ? regs[rd_sel_b] : '0;

   // apb sequencing keeps host writes away from the writeback cycle
   a_no_wr_clash: assert property (@(posedge clk) disable iff (reset)
      !(host_wr.valid && wr_en));

endmodule

`default_nettype wire

/* logic/op_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module op_decoder import i8080_pkg::*;
(
   input  logic [DATA_W-1:0] opcode,
   output exec_req_t         req
);

   reg_code_e ddd;
   reg_code_e sss;

   // pattern compare, bits set in mask are don't care
   function automatic logic match
   (
      input logic [DATA_W-1:0] op,
      input logic [DATA_W-1:0] pat,
      input logic [DATA_W-1:0] mask
   );
      return &(~(op ^ pat) | mask);
   endfunction

   function automatic alu_op_e arith_op(input logic [2:0] f);
      case (f)
         3'd0:    return op_add;
         3'd1:    return op_adc;
         3'd2:    return op_sub;
         3'd3:    return op_sbb;
         3'd4:    return op_ana;
         3'd5:    return op_xra;
         3'd6:    return op_ora;
         default: return op_cmp;
      endcase
   endfunction

   function automatic alu_op_e acc_op(input logic [2:0] f);
      case (f)
         3'd0:    return op_rlc;
         3'd1:    return op_rrc;
         3'd2:    return op_ral;
         3'd3:    return op_rar;
         3'd4:    return op_daa;
         3'd5:    return op_cma;
         3'd6:    return op_stc;
         default: return op_cmc;
      endcase
   endfunction

   assign ddd = reg_code_e'(opcode[5:3]);
   assign sss = reg_code_e'(opcode[2:0]);

   always_comb
   begin
      // unmatched codes fall through as an illegal nop
      req.op    = op_nop;
      req.dst   = reg_a;
      req.src   = reg_a;
      req.legal = 1'b0;
      if (match(opcode, 8'b00000000, 8'b00000000))
         req.legal = 1'b1;
      else if (match(opcode, 8'b01000000, 8'b00111111))
      begin
         // hlt is 01110110 and is rejected as a mov with m
         req.op    = op_mov;
         req.dst   = ddd;
         req.src   = sss;
         req.legal = (ddd != reg_m) && (sss != reg_m);
      end
      else if (match(opcode, 8'b00000100, 8'b00111000))
      begin
         req.op    = op_inr;
         req.dst   = ddd;
         req.src   = ddd;
         req.legal = (ddd != reg_m);
      end
      else if (match(opcode, 8'b00000101, 8'b00111000))
      begin
         req.op    = op_dcr;
         req.dst   = ddd;
         req.src   = ddd;
         req.legal = (ddd != reg_m);
      end
      else if (match(opcode, 8'b10000000, 8'b00111111))
      begin
         req.op    = arith_op(opcode[5:3]);
         req.src   = sss;
         req.legal = (sss != reg_m);
      end
      else if (match(opcode, 8'b00000111, 8'b00111000))
      begin
         req.op    = acc_op(opcode[5:3]);
         req.legal = 1'b1;
      end
   end

endmodule

`default_nettype wire

/* logic/apb_port.sv */
`timescale 1ns/10ps
`default_nettype none

module apb_port import i8080_pkg::*;
(
   input  logic              clk,
   input  logic              reset,
   input  logic              psel,
   input  logic              penable,
   input  logic              pwrite,
   input  logic [ADDR_W-1:0] paddr,
   input  logic [DATA_W-1:0] pwdata,
   output logic [DATA_W-1:0] prdata,
   output logic              pready,
   output logic              pslverr,
   output host_wr_t          host_wr,
   output logic [DATA_W-1:0] opcode,
   output logic              start,
   input  logic              done,
   input  logic              legal,
   input  logic [DATA_W-1:0] rd_reg,
   input  logic [DATA_W-1:0] rd_acc,
   input  flags_t            rd_flags
);

   typedef enum logic [1:0] {st_idle, st_exec, st_done} state_e;

   state_e            state;
   logic              access;
   logic              addr_reg;
   logic              addr_psw;
   logic              addr_op;
   logic              op_write;
   logic              bad_addr;
   logic [DATA_W-1:0] flag_byte;

   assign access   = psel & penable;
   assign addr_reg = (paddr <= ADDR_W'(reg_l)) | (paddr == ADDR_W'(reg_a));
   assign addr_psw = (paddr == ADDR_PSW);
   assign addr_op  = (paddr == ADDR_OPCODE);
   assign op_write = access & pwrite & addr_op & (state == st_idle);
   // the opcode register is write only
   assign bad_addr = ~(addr_reg | addr_psw | (addr_op & pwrite));

   // direct register and psw writes land on this edge
   assign host_wr.valid = access & pwrite & (addr_reg | addr_psw) & (state == st_idle);
   assign host_wr.addr  = paddr;
   assign host_wr.data  = pwdata;

   // bits 5 and 3 are zero, bit 1 is one
   assign flag_byte = {rd_flags.s, rd_flags.z, 1'b0, rd_flags.ac,
                       1'b0, rd_flags.p, 1'b1, rd_flags.c};

   always_comb
   begin
      if (addr_psw)
         prdata = flag_byte;
      else if (paddr == ADDR_W'(reg_a))
         prdata = rd_acc;
      else if (addr_reg)
         prdata = rd_reg;
      else
         prdata = '0;
   end

   // opcode writes wait for the writeback cycle
   assign pready = access & (((state == st_idle) & ~(pwrite & addr_op)) | (state == st_done));

   assign pslverr = access & (((state == st_idle) & bad_addr) | ((state == st_done) & ~legal));

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state <= st_idle;
         start <= 1'b0;
      end
      else
      begin
         start <= op_write;
         case (state)
            st_idle:
               if (op_write)
                  state <= st_exec;
            st_exec:
               state <= st_done;
            // stay pending until the datapath reports writeback
            st_done:
               if (done)
                  state <= st_idle;
            default:
               state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (op_write)
         opcode <= pwdata;
   end

   // one opcode in flight at a time
   a_single_exec: assert property (@(posedge clk) disable iff (reset)
      start |=> (!start throughout done [->1]));

endmodule

`default_nettype wire

/* logic/i8080_pkg.sv */
`default_nettype none

package i8080_pkg;

   localparam int DATA_W = 8;
   localparam int ADDR_W = 4;

   // bit positions in the flag byte
   localparam int FLAG_S  = 7;
   localparam int FLAG_Z  = 6;
   localparam int FLAG_AC = 4;
   localparam int FLAG_P  = 2;
   localparam int FLAG_C  = 0;

   // apb map, registers sit at their own codes
   localparam logic [ADDR_W-1:0] ADDR_PSW    = 4'h8;
   localparam logic [ADDR_W-1:0] ADDR_OPCODE = 4'hC;

   typedef enum logic [4:0] {
      op_nop,
      op_mov,
      op_inr,
      op_dcr,
      op_add,
      op_adc,
      op_sub,
      op_sbb,
      op_ana,
      op_xra,
      op_ora,
      op_cmp,
      op_rlc,
      op_rrc,
      op_ral,
      op_rar,
      op_daa,
      op_cma,
      op_stc,
      op_cmc
   } alu_op_e;

   // instruction register field encoding
   typedef enum logic [2:0] {
      reg_b = 3'd0,
      reg_c = 3'd1,
      reg_d = 3'd2,
      reg_e = 3'd3,
      reg_h = 3'd4,
      reg_l = 3'd5,
      reg_m = 3'd6,
      reg_a = 3'd7
   } reg_code_e;

   typedef struct packed {
      alu_op_e   op;
      reg_code_e dst;
      reg_code_e src;
      logic      legal;
   } exec_req_t;

   typedef struct packed {
      logic              valid;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] data;
   } host_wr_t;

   typedef struct packed {
      logic s;
      logic z;
      logic ac;
      logic p;
      logic c;
   } flags_t;

endpackage

`default_nettype wire
